// File: hw/qa_pkg.sv
// Shared types of the stream reader; the ring holds 256 lines and the metadata tag covers up to 512 slots
package qa_pkg;

    // ============================================================
    // Host memory geometry
    // ============================================================

    // One host cache line
    localparam int CACHE_WIDTH = 512;
    typedef logic [CACHE_WIDTH-1:0] t_cache_line;

    // Host addresses count whole lines, not bytes
    typedef logic [31:0] t_cache_line_addr;

    // Ring-buffer index
    // The ring size is a power of two, so the pointers wrap on their own
    localparam int FIFO_IDX_BITS = 8;
    typedef logic [FIFO_IDX_BITS-1:0] t_fifo_idx;

    // ============================================================
    // Request and response channel
    // ============================================================

    // Tag width in the read metadata, wide enough for a 512-slot scoreboard
    localparam int ROB_IDX_BITS = 9;

    // Width of the metadata field that the host echoes back
    localparam int MDATA_BITS = 14;

    typedef enum logic [1:0] {
        RdLine = 2'h0,
        WrLine = 2'h1
    } t_request_type;

    // Metadata sent with a read and returned with its response
    typedef struct packed {
        logic                    is_read;
        logic [ROB_IDX_BITS-1:0] rob_addr;
    } t_read_metadata;

    typedef struct packed {
        t_request_type         request_type;
        t_cache_line_addr      address;
        logic [MDATA_BITS-1:0] mdata;
    } t_tx_header;

    // One client's view of the shared request channel
    typedef struct packed {
        logic        read_request;
        logic        write_request;
        t_tx_header  read_header;
        t_tx_header  write_header;
        t_cache_line write_data;
    } t_frame_req;

    // Response channel from host memory
    typedef struct packed {
        logic                  rdvalid;
        logic                  wrvalid;
        logic [MDATA_BITS-1:0] mdata;
        t_cache_line           data;
    } t_rx_c0;

    // Registers written by the host over MMIO
    typedef struct packed {
        logic [31:0] afu_read_frame;
        logic [31:0] afu_status_addr;
        logic        newest_wr_en;
        t_fifo_idx   newest_idx;
    } t_csr_afu_state;

    // ============================================================
    // Metadata packing
    // ============================================================

    // Upper mdata bits stay zero
    function automatic logic [MDATA_BITS-1:0] pack_read_metadata(t_read_metadata meta);
        return MDATA_BITS'(meta);
    endfunction

    function automatic t_read_metadata unpack_read_metadata(logic [MDATA_BITS-1:0] mdata);
        return t_read_metadata'(mdata[$bits(t_read_metadata)-1:0]);
    endfunction

endpackage

// File: hw/qa_status_manager.sv
// Sends the oldest pointer to afu_status_addr only when it changes; it must be written before the ring is reused
module qa_status_manager
(
    input  logic                     clk,
    input  logic                     resetb,
    input  qa_pkg::t_csr_afu_state   csr,
    input  qa_pkg::t_fifo_idx        oldest_idx,
    output qa_pkg::t_fifo_idx        newest_idx,
    output qa_pkg::t_frame_req       status_req,
    input  logic                     write_grant
);
    import qa_pkg::*;

    // Oldest pointer value that last went out on the channel
    t_fifo_idx sent_idx;

    // Value carried by the pending status write
    t_fifo_idx wr_idx;
    logic      wr_req;

    t_tx_header     wr_header;

    // The host publishes its newest written line by an MMIO strobe
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest_idx <= '0;
        end
        else if (csr.newest_wr_en)
        begin
            newest_idx <= csr.newest_idx;
        end
    end

    // Track the oldest pointer and request a write whenever it moved
    // The carried value follows the pointer, so a late grant sends the newest value
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            sent_idx <= '0;
            wr_idx   <= '0;
            wr_req   <= 1'b0;
        end
        else
        begin
            wr_idx <= oldest_idx;
            if (write_grant)
            begin
                // The granted value is now what the host sees
                sent_idx <= wr_idx;
                wr_req   <= (oldest_idx != wr_idx);
            end
            else
            begin
                // Hold the request until the arbiter accepts it
                wr_req <= wr_req || (oldest_idx != sent_idx);
            end
        end
    end

    always_comb
    begin
        // The all-zero metadata keeps is_read low for the write
        wr_header              = '0;
        wr_header.request_type = WrLine;
        wr_header.address      = t_cache_line_addr'(csr.afu_status_addr);

        // This client only ever writes
        status_req               = '0;
        status_req.read_request  = 1'b0;
        status_req.write_request = wr_req;
        status_req.write_header  = wr_header;
        // The pointer sits in the low bits of the status line
        status_req.write_data    = t_cache_line'(wr_idx);
    end

endmodule

// File: hw/qa_scoreboard.sv
// N_ENTRIES must be a power of two of at least 2; deq_en outside not_empty and enq_en while full are ignored
module qa_scoreboard
#(
    parameter int N_ENTRIES   = 512,
    parameter int N_DATA_BITS = 512
)
(
    input  logic                         clk,
    input  logic                         resetb,

    // In-order slot allocation
    input  logic                         enq_en,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] enq_idx,

    // Out-of-order data fill
    input  logic                         enq_data_en,
    input  logic [$clog2(N_ENTRIES)-1:0] enq_data_idx,
    input  logic [N_DATA_BITS-1:0]       enq_data,

    // In-order release
    input  logic                         deq_en,
    output logic                         not_empty,
    output logic [N_DATA_BITS-1:0]       first
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // ============================================================
    // Pointers
    // ============================================================

    // One extra bit tells a full ring from an empty one
    logic [IDX_BITS:0] alloc_ptr;
    logic [IDX_BITS:0] release_ptr;
    logic [IDX_BITS:0] release_next;

    logic do_enq;
    logic do_deq;

    // Per-slot flag: data has arrived and the slot is not yet released
    logic [N_ENTRIES-1:0] filled;

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    // Full when the indices match but the wrap bits differ
    assign not_full = !((alloc_ptr[IDX_BITS] != release_ptr[IDX_BITS]) &&
                        (alloc_ptr[IDX_BITS-1:0] == release_ptr[IDX_BITS-1:0]));
    assign enq_idx  = alloc_ptr[IDX_BITS-1:0];

    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // Release pointer as it will be after this edge
    assign release_next = do_deq ? release_ptr + 1'b1 : release_ptr;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            alloc_ptr   <= '0;
            release_ptr <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            release_ptr <= release_next;
        end
    end

    // ============================================================
    // Slot state and data
    // ============================================================

    // A release and a fill never hit the same slot, since released slots were filled
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            filled <= '0;
        end
        else
        begin
            if (do_deq)
            begin
                filled[release_ptr[IDX_BITS-1:0]] <= 1'b0;
            end
            if (enq_data_en)
            begin
                filled[enq_data_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_data_en)
        begin
            mem[enq_data_idx] <= enq_data;
        end
    end

    // Head of the ring, read one cycle after the pointer moves as a block RAM would
    always_ff @(posedge clk)
    begin
        first <= mem[release_next[IDX_BITS-1:0]];
    end

    // The head is ready when it is allocated and its data has landed
    // A fill shows here one cycle after it is written
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            not_empty <= 1'b0;
        end
        else
        begin
            not_empty <= (alloc_ptr != release_next) &&
                         filled[release_next[IDX_BITS-1:0]];
        end
    end

endmodule

// File: hw/qa_fifo_from_host.sv
// Ring of 256 lines at afu_read_frame; lines are streamed in ring order and only the low UMF_WIDTH bits leave
module qa_fifo_from_host
#(
    parameter int N_SCOREBOARD_ENTRIES = 512,
    parameter int UMF_WIDTH            = 128
)
(
    input  logic                     clk,
    input  logic                     resetb,
    input  qa_pkg::t_csr_afu_state   csr,
    input  qa_pkg::t_rx_c0           rx0,
    input  qa_pkg::t_fifo_idx        newest_idx,
    output qa_pkg::t_fifo_idx        oldest_idx,
    output qa_pkg::t_frame_req       reader_req,
    input  logic                     read_grant,
    output logic [UMF_WIDTH-1:0]     rx_data,
    output logic                     rx_rdy,
    input  logic                     rx_enable
);
    import qa_pkg::*;

    localparam int SB_IDX_BITS = $clog2(N_SCOREBOARD_ENTRIES);

    // Next ring slot to request from the host
    t_fifo_idx next_read_idx;

    // Scoreboard slot that the next read will use
    logic [SB_IDX_BITS-1:0] slot_idx;
    logic                   slot_free;

    t_read_metadata rsp_meta;
    logic           rsp_valid;
    t_cache_line    first_line;

    t_read_metadata   req_meta;
    t_tx_header       req_header;
    t_cache_line_addr base_addr;

    // ============================================================
    // Response sorting
    // ============================================================

    // Only read responses tagged as ours go into the scoreboard
    assign rsp_meta  = unpack_read_metadata(rx0.mdata);
    assign rsp_valid = rx0.rdvalid && rsp_meta.is_read;

    qa_scoreboard
    #(
        .N_ENTRIES   (N_SCOREBOARD_ENTRIES),
        .N_DATA_BITS (CACHE_WIDTH)
    )
    i_qa_scoreboard
    (
        .clk          (clk),
        .resetb       (resetb),
        .enq_en       (read_grant),
        .not_full     (slot_free),
        .enq_idx      (slot_idx),
        .enq_data_en  (rsp_valid),
        .enq_data_idx (rsp_meta.rob_addr[SB_IDX_BITS-1:0]),
        .enq_data     (rx0.data),
        .deq_en       (rx_enable),
        .not_empty    (rx_rdy),
        .first        (first_line)
    );

    // The consumer sees a narrow slice of each line
    assign rx_data = first_line[UMF_WIDTH-1:0];

    // The oldest pointer moves as lines leave in order, so the host may reuse the slot
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            oldest_idx <= '0;
        end
        else if (rx_enable)
        begin
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

    // ============================================================
    // Read requests
    // ============================================================

    assign base_addr = t_cache_line_addr'(csr.afu_read_frame);

    always_comb
    begin
        req_meta          = '0;
        req_meta.is_read  = 1'b1;
        req_meta.rob_addr = ROB_IDX_BITS'(slot_idx);

        req_header              = '0;
        req_header.request_type = RdLine;
        // Adding the index lets the ring sit at any line address
        req_header.address      = base_addr + t_cache_line_addr'(next_read_idx);
        req_header.mdata        = pack_read_metadata(req_meta);

        reader_req = '0;
        // Read while the host has published lines we have not asked for and a slot is free
        reader_req.read_request  = (next_read_idx != newest_idx) && slot_free;
        reader_req.write_request = 1'b0;
        reader_req.read_header   = req_header;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            next_read_idx <= '0;
        end
        else if (read_grant)
        begin
            next_read_idx <= next_read_idx + 1'b1;
        end
    end

endmodule

// File: hw/qa_frame_arbiter.sv
// Serves the reader's reads and the status manager's writes only; nothing is granted while tx_almost_full is high
module qa_frame_arbiter
(
    input  logic                 clk,
    input  logic                 resetb,
    input  qa_pkg::t_frame_req   reader_req,
    input  qa_pkg::t_frame_req   status_req,
    input  logic                 tx_almost_full,
    output logic                 read_grant,
    output logic                 write_grant,
    output logic                 tx_valid,
    output qa_pkg::t_tx_header   tx_header,
    output qa_pkg::t_cache_line  tx_data
);

    // Set when the status write won last, so the reader has priority next
    logic last_was_write;

    logic rd_want;
    logic wr_want;

    assign rd_want = reader_req.read_request && !tx_almost_full;
    assign wr_want = status_req.write_request && !tx_almost_full;

    // Under contention the client that did not win last time goes first
    assign read_grant  = rd_want && (!wr_want || last_was_write);
    assign write_grant = wr_want && (!rd_want || !last_was_write);

    assign tx_valid  = read_grant || write_grant;
    assign tx_header = write_grant ? status_req.write_header : reader_req.read_header;
    // Only the status write carries a payload
    assign tx_data   = status_req.write_data;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            last_was_write <= 1'b0;
        end
        else if (write_grant)
        begin
            last_was_write <= 1'b1;
        end
        else if (read_grant)
        begin
            last_was_write <= 1'b0;
        end
    end

endmodule

// File: hw/qa_drv_top.sv
// Host-to-FPGA stream reader; tx_almost_full must rise early enough for one more request to be accepted
module qa_drv_top
#(
    parameter int N_SCOREBOARD_ENTRIES = 512,
    parameter int UMF_WIDTH            = 128
)
(
    input  logic                     clk,
    input  logic                     resetb,

    // MMIO registers from the host
    input  qa_pkg::t_csr_afu_state   csr,

    // Request channel to host memory
    output logic                     tx_valid,
    output qa_pkg::t_tx_header       tx_header,
    output qa_pkg::t_cache_line      tx_data,
    input  logic                     tx_almost_full,

    // Response channel from host memory
    input  qa_pkg::t_rx_c0           rx0,

    // Ordered stream to the consumer
    output logic [UMF_WIDTH-1:0]     rx_data,
    output logic                     rx_rdy,
    input  logic                     rx_enable
);
    import qa_pkg::*;

    // Ring pointers exchanged between the reader and the status manager
    t_fifo_idx newest_idx;
    t_fifo_idx oldest_idx;

    t_frame_req reader_req;
    t_frame_req status_req;
    logic       read_grant;
    logic       write_grant;

    qa_status_manager i_qa_status_manager
    (
        .clk         (clk),
        .resetb      (resetb),
        .csr         (csr),
        .oldest_idx  (oldest_idx),
        .newest_idx  (newest_idx),
        .status_req  (status_req),
        .write_grant (write_grant)
    );

    qa_fifo_from_host
    #(
        .N_SCOREBOARD_ENTRIES (N_SCOREBOARD_ENTRIES),
        .UMF_WIDTH            (UMF_WIDTH)
    )
    i_qa_fifo_from_host
    (
        .clk        (clk),
        .resetb     (resetb),
        .csr        (csr),
        .rx0        (rx0),
        .newest_idx (newest_idx),
        .oldest_idx (oldest_idx),
        .reader_req (reader_req),
        .read_grant (read_grant),
        .rx_data    (rx_data),
        .rx_rdy     (rx_rdy),
        .rx_enable  (rx_enable)
    );

    qa_frame_arbiter i_qa_frame_arbiter
    (
        .clk            (clk),
        .resetb         (resetb),
        .reader_req     (reader_req),
        .status_req     (status_req),
        .tx_almost_full (tx_almost_full),
        .read_grant     (read_grant),
        .write_grant    (write_grant),
        .tx_valid       (tx_valid),
        .tx_header      (tx_header),
        .tx_data        (tx_data)
    );

endmodule

// File: test/qa_drv_checker.sv
// Checks the stream and the status writes against the ring rules; expects a DUT reset before each test
module qa_drv_checker
#(
    parameter int UMF_WIDTH  = 128,
    parameter int SB_ENTRIES = 8
)
(
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  tx_valid,
    input  qa_pkg::t_tx_header    tx_header,
    input  qa_pkg::t_cache_line   tx_data,
    input  logic                  tx_almost_full,
    input  logic [UMF_WIDTH-1:0]  rx_data,
    input  logic                  rx_rdy,
    input  logic                  rx_enable,
    input  int                    published,
    output int                    consumed,
    output int                    last_status,
    output int                    error_count,
    output int                    check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import qa_pkg::*;

    string       test_name   = "none";
    logic [31:0] frame_base  = '0;
    logic [31:0] status_addr = '0;

    // Reads seen on the request channel since the last test started
    int   reads      = 0;
    // High while the DUT is in reset and for one cycle after it
    logic reset_seen = 1'b1;

    initial
    begin
        consumed    = 0;
        last_status = -1;
        error_count = 0;
        check_count = 0;
    end

    // ============================================================
    // Reporting
    // ============================================================

    task check_value(input string what, input logic [UMF_WIDTH-1:0] expected,
                     input logic [UMF_WIDTH-1:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task report_failure(input string what);
        error_count++;
        $display("Check failed in test %s: %s", test_name, what);
    endtask

    // Called by the testbench while the DUT is held in reset
    task start_test(input string name, input logic [31:0] base, input logic [31:0] status);
        test_name   = name;
        frame_base  = base;
        status_addr = status;
        reads       = 0;
        consumed    = 0;
        last_status = -1;
    endtask

    // The last status write must carry the total number of lines consumed
    task end_test(input int final_idx);
        check_value("final oldest pointer", UMF_WIDTH'(final_idx), UMF_WIDTH'(last_status));
    endtask

    // ============================================================
    // Channel monitor
    // ============================================================

    // Samples before the edge updates anything, so all values belong to the same cycle
    always @(posedge clk)
    begin
        int status_val;
        int lag;
        if (!resetb || reset_seen)
        begin
            if (tx_valid === 1'b1 || rx_rdy === 1'b1)
            begin
                report_failure("tx_valid or rx_rdy was high during or right after reset");
            end
        end
        if (resetb)
        begin
            // The channel takes nothing while it signals almost full
            if (tx_valid === 1'b1 && tx_almost_full === 1'b1)
            begin
                report_failure("a request was sent while tx_almost_full was high");
            end
            if (tx_valid === 1'b1 && tx_header.request_type == RdLine)
            begin
                // Reads walk the ring from the base in order
                check_value($sformatf("read address %0d", reads),
                            UMF_WIDTH'(frame_base + 32'(reads % 256)),
                            UMF_WIDTH'(tx_header.address));
                reads++;
            end
            else if (tx_valid === 1'b1)
            begin
                check_value("status write address", UMF_WIDTH'(status_addr),
                            UMF_WIDTH'(tx_header.address));
                status_val = int'(tx_data[7:0]);
                if (consumed == 0)
                begin
                    report_failure("a status write came before the first line was consumed");
                end
                if (last_status >= 0 && ((status_val - last_status) & 255) >= 128)
                begin
                    report_failure("the written oldest pointer moved backwards");
                end
                // The host must never see a slot as free before it was consumed
                lag = (consumed - status_val) & 255;
                if (lag >= 128)
                begin
                    report_failure("the written oldest pointer is ahead of the consumer");
                end
                last_status = status_val;
            end
            if (rx_rdy === 1'b1 && consumed >= published)
            begin
                report_failure("a line was offered beyond the published pointer");
            end
            if (rx_enable)
            begin
                // Every 32-bit word of a line holds that line's address
                check_value($sformatf("line %0d", consumed),
                            {(UMF_WIDTH/32){frame_base + 32'(consumed % 256)}}, rx_data);
                consumed++;
            end
            if (reads - consumed > SB_ENTRIES)
            begin
                report_failure($sformatf("%0d reads outstanding", reads - consumed));
            end
        end
        reset_seen = !resetb;
    end

endmodule

// File: test/tb_qa_drv_top.sv
// Runs each trace test after its own reset; the host model answers reads in random order and ignores writes
module tb_qa_drv_top;
    timeunit 1ns;
    timeprecision 1ps;

    import qa_pkg::*;

    localparam int SB_ENTRIES    = 8;
    localparam int UMF_WIDTH     = 128;
    // Lines published per MMIO strobe, far below the ring size
    localparam int PUBLISH_CHUNK = 48;

    // One read waiting in the host memory model
    typedef struct packed {
        t_cache_line_addr      addr;
        logic [MDATA_BITS-1:0] mdata;
    } t_pending;

    logic                 clk            = 1'b0;
    logic                 resetb         = 1'b0;
    t_csr_afu_state       csr;
    logic                 tx_valid;
    t_tx_header           tx_header;
    t_cache_line          tx_data;
    logic                 tx_almost_full = 1'b0;
    t_rx_c0               rx0            = '0;
    logic [UMF_WIDTH-1:0] rx_data;
    logic                 rx_rdy;
    logic                 rx_enable      = 1'b0;

    // MMIO register values
    logic [31:0] frame_base  = '0;
    logic [31:0] status_addr = '0;
    logic        newest_en   = 1'b0;
    t_fifo_idx   newest_val  = '0;

    t_pending pending[$];
    integer   seed      = 31198;
    logic     running   = 1'b0;
    int       cur_count = 0;
    int       cur_stall = 0;
    int       published = 0;

    int consumed;
    int last_status;
    int error_count;
    int check_count;
    int cycles      = 0;
    int limit       = 0;
    int total_lines = 0;

    // Trace columns, one entry per test
    string       test_name[$];
    logic [31:0] test_base[$];
    int          test_count[$];
    int          test_stall[$];
    int          test_final[$];

    always #4 clk = ~clk;

    always_comb
    begin
        csr                 = '0;
        csr.afu_read_frame  = frame_base;
        csr.afu_status_addr = status_addr;
        csr.newest_wr_en    = newest_en;
        csr.newest_idx      = newest_val;
    end

    qa_drv_top
    #(
        .N_SCOREBOARD_ENTRIES (SB_ENTRIES),
        .UMF_WIDTH            (UMF_WIDTH)
    )
    i_qa_drv_top
    (
        .clk            (clk),
        .resetb         (resetb),
        .csr            (csr),
        .tx_valid       (tx_valid),
        .tx_header      (tx_header),
        .tx_data        (tx_data),
        .tx_almost_full (tx_almost_full),
        .rx0            (rx0),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable)
    );

    qa_drv_checker
    #(
        .UMF_WIDTH  (UMF_WIDTH),
        .SB_ENTRIES (SB_ENTRIES)
    )
    i_qa_drv_checker
    (
        .clk            (clk),
        .resetb         (resetb),
        .tx_valid       (tx_valid),
        .tx_header      (tx_header),
        .tx_data        (tx_data),
        .tx_almost_full (tx_almost_full),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .published      (published),
        .consumed       (consumed),
        .last_status    (last_status),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    // ============================================================
    // Host memory model and consumer
    // ============================================================

    // Accepted reads are queued for a later response
    always @(posedge clk)
    begin
        if (resetb && tx_valid && tx_header.request_type == RdLine)
        begin
            pending.push_back('{addr: tx_header.address, mdata: tx_header.mdata});
        end
    end

    // All random draws happen here in a fixed order
    always @(negedge clk)
    begin
        int       pick;
        t_pending rsp;
        rx0            = '0;
        newest_en      = 1'b0;
        rx_enable      = 1'b0;
        tx_almost_full = 1'b0;
        if (running)
        begin
            // The host publishes the next chunk once the stream has run dry
            if (published < cur_count && published == consumed)
            begin
                published  = (published + PUBLISH_CHUNK > cur_count) ?
                             cur_count : published + PUBLISH_CHUNK;
                newest_en  = 1'b1;
                newest_val = t_fifo_idx'(published);
            end
            tx_almost_full = ($unsigned($random(seed)) % 100) < (cur_stall / 2);
            if (rx_rdy && ($unsigned($random(seed)) % 100) >= cur_stall)
            begin
                rx_enable = 1'b1;
            end
            // Answer a random waiting read, which shuffles the responses
            if (pending.size() > 0 && ($unsigned($random(seed)) % 100) < 40)
            begin
                pick        = $unsigned($random(seed)) % pending.size();
                rsp         = pending[pick];
                rx0.rdvalid = 1'b1;
                rx0.mdata   = rsp.mdata;
                rx0.data    = {16{rsp.addr}};
                pending.delete(pick);
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    task read_trace(output bit ok);
        int          fd;
        string       line;
        string       name;
        logic [31:0] base;
        int          count;
        int          stall;
        int          final_idx;
        ok = 1'b0;
        fd = $fopen("test/qa_drv_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the trace file test/qa_drv_trace.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %h %d %d %h", name, base, count, stall, final_idx) == 5)
                begin
                    test_name.push_back(name);
                    test_base.push_back(base);
                    test_count.push_back(count);
                    test_stall.push_back(stall);
                    test_final.push_back(final_idx);
                    total_lines += count;
                end
            end
            $fclose(fd);
            ok = (test_name.size() > 0);
            if (!ok)
            begin
                $display("The trace file holds no test");
            end
        end
    endtask

    task run_test(input int t);
        int waited;
        waited = 0;
        // Set up the next test while the DUT is held in reset
        resetb      = 1'b0;
        frame_base  = test_base[t];
        // The status line sits just below the ring
        status_addr = test_base[t] - 32'd1;
        cur_count   = test_count[t];
        cur_stall   = test_stall[t];
        published   = 0;
        i_qa_drv_checker.start_test(test_name[t], frame_base, status_addr);
        repeat (8) @(negedge clk);
        resetb = 1'b1;
        // The stimulus starts and stops between two falling edges
        @(posedge clk);
        running = 1'b1;
        while (consumed < cur_count)
        begin
            @(negedge clk);
        end
        // The final status write follows the last line within a few cycles
        while (last_status != test_final[t] && waited < 64)
        begin
            @(negedge clk);
            waited++;
        end
        i_qa_drv_checker.end_test(test_final[t]);
        @(posedge clk);
        running = 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        bit ok;
        read_trace(ok);
        if (!ok)
        begin
            $display("Result: FAILED");
            $finish;
        end
        else
        begin
            limit = 400 * total_lines + 1000;
            for (int t = 0; t < test_name.size(); t++)
            begin
                run_test(t);
            end
            $display("Tests: %0d, lines: %0d, checks: %0d, errors: %0d",
                     test_name.size(), total_lines, check_count, error_count);
            if (error_count == 0)
            begin
                $display("Result: PASSED");
            end
            else
            begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

    // Ends a run that stops making progress
    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles >= limit)
        begin
            $display("Timeout after %0d cycles with %0d lines consumed", cycles, consumed);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// File: test/qa_drv_trace.txt
# Columns: test name, ring base (hex line address), line count, consumer stall percent,
# expected final oldest pointer (hex, line count modulo 256)
in_order_short   00001000   40   0  28
unaligned_base   00002345  100  20  64
publish_limit    00010000  150  10  96
ring_wrap        0003007b  400  10  90
consumer_stall   00050010  200  60  c8
full_ring        000600ff  256  30  00
single_line      00070000    1   0  01

// File: qa_drv_top.f
hw/qa_pkg.sv
hw/qa_status_manager.sv
hw/qa_scoreboard.sv
hw/qa_fifo_from_host.sv
hw/qa_frame_arbiter.sv
hw/qa_drv_top.sv
test/qa_drv_checker.sv
test/tb_qa_drv_top.sv

// File: Bender.yml
package:
  name: qa_drv

sources:
  - hw/qa_pkg.sv
  - hw/qa_status_manager.sv
  - hw/qa_scoreboard.sv
  - hw/qa_fifo_from_host.sv
  - hw/qa_frame_arbiter.sv
  - hw/qa_drv_top.sv
  - target: test
    files:
      - test/qa_drv_checker.sv
      - test/tb_qa_drv_top.sv
